// ==== verilog/btb_config.svh ====
`ifndef BTB_CONFIG_SVH
`define BTB_CONFIG_SVH

// fetch slots looked up per cycle
`define BP_N 2

// btb geometry
`define BTB_NUM_SETS 8
`define BTB_NUM_WAYS 4

// log2 of the set count
`define BTB_SET_IDX_BITS 3

// bimodal direction counters
`define BP_COUNTER_ENTRIES 64

// byte address width
`define BP_ADDR_BITS 32

`endif

// ==== verilog/fetch_types_pkg.sv ====
`include "btb_config.svh"

package fetch_types_pkg;

    // one byte address
    typedef logic [`BP_ADDR_BITS-1:0] addr_t;

    // whatever is left above set index and word offset
    localparam int BTB_TAG_BITS = `BP_ADDR_BITS - `BTB_SET_IDX_BITS - 2;

    typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;
    typedef logic [`BTB_SET_IDX_BITS-1:0] btb_set_idx_t;

    // pc as seen by the btb
    typedef struct packed {
        btb_tag_t     tag;
        btb_set_idx_t set_idx;
        logic [1:0]   word_offset;
    } pc_fields_t;

    // same word, raw or split into btb fields
    typedef union packed {
        addr_t      raw;
        pc_fields_t fields;
    } pc_word_u;

endpackage

// ==== verilog/predictor_types_pkg.sv ====
`include "btb_config.svh"

package predictor_types_pkg;

    // recency rank within a set
    // highest is most recent, 0 is next victim
    typedef logic [$clog2(`BTB_NUM_WAYS)-1:0] lru_rank_t;

    // one btb way
    typedef struct packed {
        logic                      valid;
        fetch_types_pkg::btb_tag_t tag;
        fetch_types_pkg::addr_t    target;
        lru_rank_t                 rank;
    } btb_entry_t;

    // two-bit bimodal state
    // msb is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

endpackage

// ==== verilog/btb.sv ====
`timescale 1ns/100ps
`include "btb_config.svh"

module btb (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    btb_flush,
    input  fetch_types_pkg::addr_t [`BP_N-1:0]      slot_pcs,
    input  logic                                    resolve_write,
    input  fetch_types_pkg::addr_t                  resolve_pc,
    input  fetch_types_pkg::addr_t                  resolve_target,
    output fetch_types_pkg::addr_t [`BP_N-1:0]      target_pcs,
    output logic                   [`BP_N-1:0]      btb_hit
);
    import fetch_types_pkg::*;
    import predictor_types_pkg::*;

    localparam int WAY_BITS = $clog2(`BTB_NUM_WAYS);
    localparam lru_rank_t TOP_RANK = lru_rank_t'(`BTB_NUM_WAYS - 1);

    btb_entry_t entries_q    [`BTB_NUM_SETS][`BTB_NUM_WAYS];
    btb_entry_t entries_next [`BTB_NUM_SETS][`BTB_NUM_WAYS];

    // write side decode
    pc_word_u           wr_pc;
    logic               have_way;
    logic [WAY_BITS-1:0] wr_way;
    lru_rank_t          old_rank;

    assign wr_pc.raw = resolve_pc;

    always_comb begin
        entries_next = entries_q;
        have_way     = 1'b0;
        wr_way       = '0;
        old_rank     = '0;
        // flush drops everything back to reset ordering
        if (btb_flush) begin
            for (int s = 0; s < `BTB_NUM_SETS; s++) begin
                for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                    entries_next[s][w].valid = 1'b0;
                    entries_next[s][w].rank  = '0;
                end
            end
        end
        if (resolve_write) begin
            // first choice is a valid way with the same tag
            for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                if (!have_way && entries_next[wr_pc.fields.set_idx][w].valid &&
                    entries_next[wr_pc.fields.set_idx][w].tag == wr_pc.fields.tag) begin
                    have_way = 1'b1;
                    wr_way   = WAY_BITS'(w);
                end
            end
            // then the lowest empty way
            for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                if (!have_way && !entries_next[wr_pc.fields.set_idx][w].valid) begin
                    have_way = 1'b1;
                    wr_way   = WAY_BITS'(w);
                end
            end
            // full set so evict the rank 0 way
            for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                if (!have_way && entries_next[wr_pc.fields.set_idx][w].rank == '0) begin
                    have_way = 1'b1;
                    wr_way   = WAY_BITS'(w);
                end
            end
            old_rank = entries_next[wr_pc.fields.set_idx][wr_way].rank;
            // everything newer than the chosen way ages by one
            for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                if (entries_next[wr_pc.fields.set_idx][w].valid &&
                    entries_next[wr_pc.fields.set_idx][w].rank > old_rank) begin
                    entries_next[wr_pc.fields.set_idx][w].rank =
                        entries_next[wr_pc.fields.set_idx][w].rank - 1'b1;
                end
            end
            // chosen way becomes most recent
            entries_next[wr_pc.fields.set_idx][wr_way].valid  = 1'b1;
            entries_next[wr_pc.fields.set_idx][wr_way].tag    = wr_pc.fields.tag;
            entries_next[wr_pc.fields.set_idx][wr_way].target = resolve_target;
            entries_next[wr_pc.fields.set_idx][wr_way].rank   = TOP_RANK;
        end
    end

    // read side looks at next state
    // a resolve in this cycle is already visible
    pc_word_u rd_pc [`BP_N];

    always_comb begin
        for (int s = 0; s < `BP_N; s++) begin
            rd_pc[s].raw  = slot_pcs[s];
            btb_hit[s]    = 1'b0;
            target_pcs[s] = '0;
            for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                if (entries_next[rd_pc[s].fields.set_idx][w].valid &&
                    entries_next[rd_pc[s].fields.set_idx][w].tag == rd_pc[s].fields.tag) begin
                    btb_hit[s]    = 1'b1;
                    target_pcs[s] = entries_next[rd_pc[s].fields.set_idx][w].target;
                end
            end
        end
    end

    // reset empties every way
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `BTB_NUM_SETS; s++) begin
                for (int w = 0; w < `BTB_NUM_WAYS; w++) begin
                    entries_q[s][w].valid <= 1'b0;
                    entries_q[s][w].rank  <= '0;
                end
            end
        end else begin
            entries_q <= entries_next;
        end
    end

endmodule

// ==== verilog/bimodal_table.sv ====
`timescale 1ns/100ps
`include "btb_config.svh"

module bimodal_table (
    input  logic                               clock,
    input  logic                               reset,
    input  fetch_types_pkg::addr_t [`BP_N-1:0] slot_pcs,
    input  logic                               resolve_valid,
    input  logic                               resolve_taken,
    input  fetch_types_pkg::addr_t             resolve_pc,
    output logic                   [`BP_N-1:0] predict_taken_dir
);
    import fetch_types_pkg::*;
    import predictor_types_pkg::*;

    localparam int IDX_BITS = $clog2(`BP_COUNTER_ENTRIES);

    counter_t counters_q    [`BP_COUNTER_ENTRIES];
    counter_t counters_next [`BP_COUNTER_ENTRIES];

    // index from word address bits above the byte offset
    pc_word_u            res_pc;
    logic [IDX_BITS-1:0] res_idx;

    assign res_pc.raw = resolve_pc;
    assign res_idx    = res_pc.raw[IDX_BITS+1:2];

    // saturating step toward the resolved outcome
    always_comb begin
        counters_next = counters_q;
        if (resolve_valid) begin
            unique case (counters_q[res_idx])
                STRONG_NT: counters_next[res_idx] = resolve_taken ? WEAK_NT  : STRONG_NT;
                WEAK_NT:   counters_next[res_idx] = resolve_taken ? WEAK_T   : STRONG_NT;
                WEAK_T:    counters_next[res_idx] = resolve_taken ? STRONG_T : WEAK_NT;
                default:   counters_next[res_idx] = resolve_taken ? STRONG_T : WEAK_T;
            endcase
        end
    end

    // lookup reads the updated counters
    pc_word_u slot_word [`BP_N];

    always_comb begin
        for (int s = 0; s < `BP_N; s++) begin
            slot_word[s].raw     = slot_pcs[s];
            predict_taken_dir[s] = counters_next[slot_word[s].raw[IDX_BITS+1:2]][1];
        end
    end

    // start everything one step short of taken
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `BP_COUNTER_ENTRIES; i++) begin
                counters_q[i] <= WEAK_NT;
            end
        end else begin
            counters_q <= counters_next;
        end
    end

endmodule

// ==== verilog/predict_ctrl.sv ====
`timescale 1ns/100ps

module predict_ctrl (
    input  logic       clock,
    input  logic       reset,
    input  logic       ctrl_write,
    input  logic [2:0] ctrl_data,
    output logic       predict_enable,
    output logic       use_direction,
    output logic       btb_flush
);
    // control word layout
    localparam int ENABLE_BIT    = 0;
    localparam int DIRECTION_BIT = 1;
    localparam int FLUSH_BIT     = 2;

    logic flush_req;

    // flush request only counts on a write
    assign flush_req = ctrl_write && ctrl_data[FLUSH_BIT];

    always_ff @(posedge clock) begin
        if (reset) begin
            predict_enable <= 1'b0;
            use_direction  <= 1'b0;
            btb_flush      <= 1'b0;
        end else begin
            // single cycle pulse, nothing kept
            btb_flush <= flush_req;
            // mode bits held until the next write
            if (ctrl_write) begin
                predict_enable <= ctrl_data[ENABLE_BIT];
                use_direction  <= ctrl_data[DIRECTION_BIT];
            end
        end
    end

endmodule

// ==== verilog/next_pc_select.sv ====
`timescale 1ns/100ps
`include "btb_config.svh"

module next_pc_select (
    input  fetch_types_pkg::addr_t             fetch_pc,
    input  logic                   [`BP_N-1:0] btb_hit,
    input  logic                   [`BP_N-1:0] predict_taken_dir,
    input  fetch_types_pkg::addr_t [`BP_N-1:0] target_pcs,
    input  logic                               predict_enable,
    input  logic                               use_direction,
    output fetch_types_pkg::addr_t [`BP_N-1:0] slot_pcs,
    output fetch_types_pkg::addr_t             next_fetch_pc,
    output logic                   [`BP_N-1:0] slot_valid
);
    import fetch_types_pkg::*;

    pc_word_u         base_pc;
    logic [`BP_N-1:0] slot_taken;

    assign base_pc.raw = fetch_pc;

    // consecutive words after the aligned fetch pc
    always_comb begin
        for (int s = 0; s < `BP_N; s++) begin
            slot_pcs[s] = base_pc.raw + addr_t'(4 * s);
        end
    end

    // btb hit alone is enough unless direction is in use
    assign slot_taken = {`BP_N{predict_enable}} & btb_hit &
                        (~{`BP_N{use_direction}} | predict_taken_dir);

    // default is sequential fall-through
    // walk high to low so the lowest taken slot wins
    always_comb begin
        next_fetch_pc = base_pc.raw + addr_t'(4 * `BP_N);
        slot_valid    = '1;
        for (int s = `BP_N - 1; s >= 0; s--) begin
            if (slot_taken[s]) begin
                next_fetch_pc = target_pcs[s];
                // slots past the taken branch are dropped
                for (int k = 0; k < `BP_N; k++) begin
                    slot_valid[k] = (k <= s);
                end
            end
        end
    end

endmodule

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/100ps
`include "btb_config.svh"

module branch_predictor (
    input  logic                               clock,
    input  logic                               reset,
    input  fetch_types_pkg::addr_t             fetch_pc,
    input  logic                               resolve_valid,
    input  fetch_types_pkg::addr_t             resolve_pc,
    input  fetch_types_pkg::addr_t             resolve_target,
    input  logic                               resolve_taken,
    input  logic                               ctrl_write,
    input  logic                   [2:0]       ctrl_data,
    output fetch_types_pkg::addr_t             next_fetch_pc,
    output logic                   [`BP_N-1:0] slot_valid
);
    import fetch_types_pkg::*;

    // per-slot lookup path
    addr_t [`BP_N-1:0] slot_pcs;
    addr_t [`BP_N-1:0] target_pcs;
    logic  [`BP_N-1:0] btb_hit;
    logic  [`BP_N-1:0] predict_taken_dir;

    // mode bits and flush pulse
    logic predict_enable;
    logic use_direction;
    logic btb_flush;

    predict_ctrl ctrl0 (
        .clock          (clock),
        .reset          (reset),
        .ctrl_write     (ctrl_write),
        .ctrl_data      (ctrl_data),
        .predict_enable (predict_enable),
        .use_direction  (use_direction),
        .btb_flush      (btb_flush)
    );

    // only taken branches are installed
    btb btb0 (
        .clock          (clock),
        .reset          (reset),
        .btb_flush      (btb_flush),
        .slot_pcs       (slot_pcs),
        .resolve_write  (resolve_valid & resolve_taken),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .target_pcs     (target_pcs),
        .btb_hit        (btb_hit)
    );

    // counters train on every resolution
    bimodal_table bim0 (
        .clock             (clock),
        .reset             (reset),
        .slot_pcs          (slot_pcs),
        .resolve_valid     (resolve_valid),
        .resolve_taken     (resolve_taken),
        .resolve_pc        (resolve_pc),
        .predict_taken_dir (predict_taken_dir)
    );

    next_pc_select sel0 (
        .fetch_pc          (fetch_pc),
        .btb_hit           (btb_hit),
        .predict_taken_dir (predict_taken_dir),
        .target_pcs        (target_pcs),
        .predict_enable    (predict_enable),
        .use_direction     (use_direction),
        .slot_pcs          (slot_pcs),
        .next_fetch_pc     (next_fetch_pc),
        .slot_valid        (slot_valid)
    );

endmodule

// ==== bench/branch_predictor_tb.sv ====
`timescale 1ns/100ps
`include "btb_config.svh"

module branch_predictor_tb;
    import fetch_types_pkg::*;

    localparam int MAX_ROWS      = 48;
    localparam int RESET_TIMEOUT = 20;
    localparam logic [`BP_N-1:0] ALL_SLOTS  = '1;
    localparam logic [`BP_N-1:0] SLOT0_ONLY = `BP_N'(1);

    typedef enum logic [1:0] {OP_RESOLVE, OP_CTRL, OP_LOOKUP} op_e;

    logic             clock;
    logic             reset;
    addr_t            fetch_pc;
    logic             resolve_valid;
    addr_t            resolve_pc;
    addr_t            resolve_target;
    logic             resolve_taken;
    logic             ctrl_write;
    logic [2:0]       ctrl_data;
    addr_t            next_fetch_pc;
    logic [`BP_N-1:0] slot_valid;

    // stimulus table, one row per cycle
    string            row_name     [MAX_ROWS];
    op_e              row_op       [MAX_ROWS];
    addr_t            row_pc       [MAX_ROWS];
    addr_t            row_target   [MAX_ROWS];
    logic             row_taken    [MAX_ROWS];
    logic [2:0]       row_ctrl     [MAX_ROWS];
    addr_t            row_exp_pc   [MAX_ROWS];
    logic [`BP_N-1:0] row_exp_mask [MAX_ROWS];
    int               row_count;

    int error_count;
    int timeout_count;
    int reset_cycles;

    branch_predictor dut0 (
        .clock          (clock),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .resolve_taken  (resolve_taken),
        .ctrl_write     (ctrl_write),
        .ctrl_data      (ctrl_data),
        .next_fetch_pc  (next_fetch_pc),
        .slot_valid     (slot_valid)
    );

    // 20 ns period
    always #10 clock = ~clock;

    // reset over the first three rising edges
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // random tag, forced into one btb set and word aligned
    function automatic addr_t pc_in_set(input logic [31:0] value, input int set_idx);
        pc_word_u word;
        word.raw                = value;
        word.fields.set_idx     = btb_set_idx_t'(set_idx);
        word.fields.word_offset = 2'b00;
        return word.raw;
    endfunction

    // sequential next fetch, past all slots
    function automatic addr_t fall_through(input addr_t pc);
        return pc + addr_t'(4 * `BP_N);
    endfunction

    task automatic push_row(input string name, input op_e op, input addr_t pc,
                            input addr_t target, input logic taken, input logic [2:0] ctrl,
                            input addr_t exp_pc, input logic [`BP_N-1:0] exp_mask);
        if (row_count >= MAX_ROWS) begin
            $display("stimulus table is full, row %s dropped", name);
            error_count++;
        end else begin
            row_name[row_count]     = name;
            row_op[row_count]       = op;
            row_pc[row_count]       = pc;
            row_target[row_count]   = target;
            row_taken[row_count]    = taken;
            row_ctrl[row_count]     = ctrl;
            row_exp_pc[row_count]   = exp_pc;
            row_exp_mask[row_count] = exp_mask;
            row_count++;
        end
    endtask

    task automatic expect_lookup(input string name, input addr_t pc, input addr_t exp_pc,
                                 input logic [`BP_N-1:0] exp_mask);
        push_row(name, OP_LOOKUP, pc, '0, 1'b0, 3'b000, exp_pc, exp_mask);
    endtask

    task automatic train_branch(input string name, input addr_t pc, input addr_t target,
                                input logic taken);
        push_row(name, OP_RESOLVE, pc, target, taken, 3'b000, '0, '0);
    endtask

    // ctrl bits are flush, use_direction, predict_enable
    task automatic write_ctrl(input string name, input logic [2:0] bits);
        push_row(name, OP_CTRL, '0, '0, 1'b0, bits, '0, '0);
    endtask

    task automatic build_table();
        logic [31:0] seed;
        addr_t       lru_pc     [5];
        addr_t       lru_target [5];
        seed = 32'd17;
        // eviction candidates, all in set 6
        for (int i = 0; i < 5; i++) begin
            seed          = lcg_next(seed);
            lru_pc[i]     = pc_in_set(seed, 6);
            seed          = lcg_next(seed);
            lru_target[i] = {seed[31:2], 2'b00};
        end
        row_count = 0;
        // disabled out of reset even with a btb hit
        train_branch("install_cold", 32'h8000, 32'h9000, 1'b1);
        expect_lookup("reset_fallthrough", 32'h8000, fall_through(32'h8000), ALL_SLOTS);
        write_ctrl("enable_btb_only", 3'b001);
        expect_lookup("enabled_cold", 32'h2000, fall_through(32'h2000), ALL_SLOTS);
        // btb hit alone decides
        train_branch("install_slot1", 32'h1004, 32'h3000, 1'b1);
        expect_lookup("slot1_taken", 32'h1000, 32'h3000, ALL_SLOTS);
        train_branch("install_slot0", 32'h1000, 32'h4000, 1'b1);
        expect_lookup("slot0_overrides", 32'h1000, 32'h4000, SLOT0_ONLY);
        // counter msb gates the hit, starts weakly not taken
        write_ctrl("enable_direction", 3'b011);
        train_branch("install_dir", 32'h5010, 32'h6000, 1'b1);
        expect_lookup("dir_weak_taken", 32'h5010, 32'h6000, SLOT0_ONLY);
        // not taken trains the counter only, btb keeps the old target
        train_branch("dir_not_taken", 32'h5010, 32'h7000, 1'b0);
        expect_lookup("dir_fallthrough", 32'h5010, fall_through(32'h5010), ALL_SLOTS);
        // fill set 6, refresh the first, then a fifth evicts the second
        write_ctrl("btb_only_again", 3'b001);
        expect_lookup("dir_btb_still_hits", 32'h5010, 32'h6000, SLOT0_ONLY);
        for (int i = 0; i < 4; i++) begin
            train_branch("lru_fill", lru_pc[i], lru_target[i], 1'b1);
        end
        train_branch("lru_refresh", lru_pc[0], lru_target[0], 1'b1);
        train_branch("lru_evict", lru_pc[4], lru_target[4], 1'b1);
        expect_lookup("lru_refreshed_hit", lru_pc[0], lru_target[0], SLOT0_ONLY);
        expect_lookup("lru_victim_miss", lru_pc[1], fall_through(lru_pc[1]), ALL_SLOTS);
        expect_lookup("lru_newest_hit", lru_pc[4], lru_target[4], SLOT0_ONLY);
        // flush drops every entry, mode bits kept
        write_ctrl("flush", 3'b101);
        expect_lookup("flush_miss_slot0", 32'h1000, fall_through(32'h1000), ALL_SLOTS);
        expect_lookup("flush_miss_lru", lru_pc[4], fall_through(lru_pc[4]), ALL_SLOTS);
        train_branch("reinstall", 32'h1000, 32'h4000, 1'b1);
        expect_lookup("reinstall_hit", 32'h1000, 32'h4000, SLOT0_ONLY);
        // disabled predictor ignores the hit
        write_ctrl("disable", 3'b000);
        expect_lookup("disabled_fallthrough", 32'h1000, fall_through(32'h1000), ALL_SLOTS);
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_mask(input string name, input logic [`BP_N-1:0] expected,
                              input logic [`BP_N-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    // drive on the rising edge, sample at the falling edge
    task automatic drive_row(input int i);
        @(posedge clock);
        resolve_valid <= 1'b0;
        ctrl_write    <= 1'b0;
        case (row_op[i])
            OP_RESOLVE: begin
                resolve_valid  <= 1'b1;
                resolve_pc     <= row_pc[i];
                resolve_target <= row_target[i];
                resolve_taken  <= row_taken[i];
            end
            OP_CTRL: begin
                ctrl_write <= 1'b1;
                ctrl_data  <= row_ctrl[i];
            end
            default: begin
                fetch_pc <= row_pc[i];
            end
        endcase
        @(negedge clock);
        if (row_op[i] == OP_LOOKUP) begin
            check_addr(row_name[i], row_exp_pc[i], next_fetch_pc);
            check_mask(row_name[i], row_exp_mask[i], slot_valid);
        end
    endtask

    initial begin
        fetch_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_target = '0;
        resolve_taken  = 1'b0;
        ctrl_write     = 1'b0;
        ctrl_data      = 3'b000;
        error_count    = 0;
        timeout_count  = 0;
        reset_cycles   = 0;
        build_table();
        // bounded wait for reset release
        @(negedge clock);
        while (reset !== 1'b0 && reset_cycles < RESET_TIMEOUT) begin
            @(negedge clock);
            reset_cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset never finished within %0d cycles", RESET_TIMEOUT);
            timeout_count++;
        end else begin
            for (int i = 0; i < row_count; i++) begin
                drive_row(i);
            end
        end
        $display("rows %0d, value errors %0d, timeouts %0d",
                 row_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== btb_predict.f ====
+incdir+verilog
verilog/fetch_types_pkg.sv
verilog/predictor_types_pkg.sv
verilog/btb.sv
verilog/bimodal_table.sv
verilog/predict_ctrl.sv
verilog/next_pc_select.sv
verilog/branch_predictor.sv
bench/branch_predictor_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --timing
TOP       := branch_predictor_tb
RTL_TOP   := branch_predictor
FILELIST  := btb_predict.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
